// ==== rtl/rv_pkg.sv ====
package rv_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [4:0]      reg_addr_t;
    typedef logic [4:0]      inst_num_t;
    typedef logic [2:0]      inst_type_t;

    // Instruction numbers, one per supported op
    localparam inst_num_t OP_LUI    = 5'd0;
    localparam inst_num_t OP_AUIPC  = 5'd1;
    localparam inst_num_t OP_JAL    = 5'd2;
    localparam inst_num_t OP_JALR   = 5'd3;
    localparam inst_num_t OP_BEQ    = 5'd4;
    localparam inst_num_t OP_BNE    = 5'd5;
    localparam inst_num_t OP_BLT    = 5'd6;
    localparam inst_num_t OP_BGE    = 5'd7;
    localparam inst_num_t OP_BLTU   = 5'd8;
    localparam inst_num_t OP_BGEU   = 5'd9;
    localparam inst_num_t OP_ADDI   = 5'd10;
    localparam inst_num_t OP_SLTIU  = 5'd11;
    localparam inst_num_t OP_XORI   = 5'd12;
    localparam inst_num_t OP_ANDI   = 5'd13;
    localparam inst_num_t OP_SLLI   = 5'd14;
    localparam inst_num_t OP_SRLI   = 5'd15;
    localparam inst_num_t OP_SRAI   = 5'd16;
    localparam inst_num_t OP_ADD    = 5'd17;
    localparam inst_num_t OP_SUB    = 5'd18;
    localparam inst_num_t OP_SLL    = 5'd19;
    localparam inst_num_t OP_SLTU   = 5'd20;
    localparam inst_num_t OP_XOR    = 5'd21;
    localparam inst_num_t OP_OR     = 5'd22;
    localparam inst_num_t OP_AND    = 5'd23;
    localparam inst_num_t OP_EBREAK = 5'd24;

    localparam int INST_NUM_MAX = 25;

    // First number past the table marks an unsupported encoding
    localparam inst_num_t OP_ILLEGAL = inst_num_t'(INST_NUM_MAX);

    localparam inst_type_t TYPE_R    = 3'd0;
    localparam inst_type_t TYPE_I    = 3'd1;
    localparam inst_type_t TYPE_S    = 3'd2;
    localparam inst_type_t TYPE_B    = 3'd3;
    localparam inst_type_t TYPE_U    = 3'd4;
    localparam inst_type_t TYPE_J    = 3'd5;
    localparam inst_type_t TYPE_NONE = 3'd7;

    typedef struct packed {
        inst_num_t  op;
        inst_type_t itype;
        reg_addr_t  rd;
        reg_addr_t  rs1;
        reg_addr_t  rs2;
        xlen_t      imm;
        logic       rd_w_en;
        logic       halt;
    } dec_t;

    typedef struct packed {
        logic      valid;
        xlen_t     pc;
        reg_addr_t rd;
        logic      rd_w_en;
        xlen_t     rd_data;
    } commit_t;

    typedef enum logic [1:0] {
        FETCH,
        HALTED,
        TRAPPED
    } fetch_state_e;

endpackage

// ==== rtl/ifu_fetch.sv ====
`timescale 1ns/10ps

module ifu_fetch #(
    parameter rv_pkg::xlen_t RESET_PC = '0
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          wb_ack,
    input  rv_pkg::xlen_t wb_dat_i,
    input  rv_pkg::xlen_t next_pc,
    input  logic          pc_w_en,
    input  logic          halt,
    output logic          wb_cyc,
    output logic          wb_stb,
    output logic          wb_we,
    output rv_pkg::xlen_t wb_adr,
    output rv_pkg::xlen_t inst,
    output rv_pkg::xlen_t pc,
    output logic          retire,
    output logic          halted,
    output logic          trapped
);

    rv_pkg::fetch_state_e state_q;
    rv_pkg::xlen_t        pc_q;
    logic                 run_q;
    logic                 accept;

    // Bus stays idle for the first cycle out of reset
    assign wb_cyc = run_q && (state_q == rv_pkg::FETCH);
    assign wb_stb = wb_cyc;
    assign wb_we  = 1'b0;
    assign wb_adr = pc_q;

    assign accept  = wb_cyc && wb_stb && wb_ack;
    assign retire  = accept && pc_w_en;
    assign inst    = wb_dat_i;
    assign pc      = pc_q;
    assign halted  = (state_q == rv_pkg::HALTED);
    assign trapped = (state_q == rv_pkg::TRAPPED);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            run_q   <= 1'b0;
            state_q <= rv_pkg::FETCH;
            pc_q    <= RESET_PC;
        end else begin
            run_q <= 1'b1;
            if (accept) begin
                if (!pc_w_en) begin
                    state_q <= rv_pkg::TRAPPED;
                end else if (halt) begin
                    state_q <= rv_pkg::HALTED;
                end else begin
                    pc_q <= next_pc;
                end
            end
        end
    end

    a_adr_stable_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_cyc && wb_stb && !wb_ack) |=> $stable(wb_adr));

    a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        pc_q[1:0] == 2'b00);

endmodule

// ==== rtl/idu_decode.sv ====
`timescale 1ns/10ps

module idu_decode (
    input  rv_pkg::xlen_t inst,
    output rv_pkg::dec_t  dec
);

    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    localparam rv_pkg::xlen_t EBREAK_WORD = 32'h0010_0073;

    logic [6:0]         opcode;
    logic [2:0]         funct3;
    logic [6:0]         funct7;
    rv_pkg::inst_num_t  op;
    rv_pkg::inst_type_t fmt;
    rv_pkg::inst_type_t itype;
    rv_pkg::xlen_t      imm;
    logic               rd_w_en;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    always_comb begin
        op  = rv_pkg::OP_ILLEGAL;
        fmt = rv_pkg::TYPE_NONE;
        case (opcode)
            OPC_LUI: begin
                op  = rv_pkg::OP_LUI;
                fmt = rv_pkg::TYPE_U;
            end
            OPC_AUIPC: begin
                op  = rv_pkg::OP_AUIPC;
                fmt = rv_pkg::TYPE_U;
            end
            OPC_JAL: begin
                op  = rv_pkg::OP_JAL;
                fmt = rv_pkg::TYPE_J;
            end
            OPC_JALR: begin
                fmt = rv_pkg::TYPE_I;
                if (funct3 == 3'b000) op = rv_pkg::OP_JALR;
            end
            OPC_BRANCH: begin
                fmt = rv_pkg::TYPE_B;
                case (funct3)
                    3'b000:  op = rv_pkg::OP_BEQ;
                    3'b001:  op = rv_pkg::OP_BNE;
                    3'b100:  op = rv_pkg::OP_BLT;
                    3'b101:  op = rv_pkg::OP_BGE;
                    3'b110:  op = rv_pkg::OP_BLTU;
                    3'b111:  op = rv_pkg::OP_BGEU;
                    default: ;
                endcase
            end
            OPC_OP_IMM: begin
                fmt = rv_pkg::TYPE_I;
                case (funct3)
                    3'b000: op = rv_pkg::OP_ADDI;
                    3'b011: op = rv_pkg::OP_SLTIU;
                    3'b100: op = rv_pkg::OP_XORI;
                    3'b111: op = rv_pkg::OP_ANDI;
                    3'b001: if (funct7 == F7_BASE) op = rv_pkg::OP_SLLI;
                    3'b101: begin
                        if (funct7 == F7_BASE) op = rv_pkg::OP_SRLI;
                        else if (funct7 == F7_ALT) op = rv_pkg::OP_SRAI;
                    end
                    default: ;
                endcase
            end
            OPC_OP: begin
                fmt = rv_pkg::TYPE_R;
                if (funct7 == F7_BASE) begin
                    case (funct3)
                        3'b000:  op = rv_pkg::OP_ADD;
                        3'b001:  op = rv_pkg::OP_SLL;
                        3'b011:  op = rv_pkg::OP_SLTU;
                        3'b100:  op = rv_pkg::OP_XOR;
                        3'b110:  op = rv_pkg::OP_OR;
                        3'b111:  op = rv_pkg::OP_AND;
                        default: ;
                    endcase
                end else if (funct7 == F7_ALT && funct3 == 3'b000) begin
                    op = rv_pkg::OP_SUB;
                end
            end
            OPC_SYSTEM: begin
                fmt = rv_pkg::TYPE_I;
                if (inst == EBREAK_WORD) op = rv_pkg::OP_EBREAK;
            end
            default: ;
        endcase
    end

    assign itype = (op == rv_pkg::OP_ILLEGAL) ? rv_pkg::TYPE_NONE : fmt;

    always_comb begin
        case (itype)
            rv_pkg::TYPE_I: imm = {{20{inst[31]}}, inst[31:20]};
            rv_pkg::TYPE_B: imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            rv_pkg::TYPE_U: imm = {inst[31:12], 12'b0};
            rv_pkg::TYPE_J: imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            default:        imm = '0;
        endcase
    end

    // Branches and ebreak write nothing, and x0 is never a target
    assign rd_w_en = (itype == rv_pkg::TYPE_R || itype == rv_pkg::TYPE_I ||
                      itype == rv_pkg::TYPE_U || itype == rv_pkg::TYPE_J) &&
                     (op != rv_pkg::OP_EBREAK) && (inst[11:7] != 5'd0);

    assign dec = '{
        op:      op,
        itype:   itype,
        rd:      inst[11:7],
        rs1:     inst[19:15],
        rs2:     inst[24:20],
        imm:     imm,
        rd_w_en: rd_w_en,
        halt:    (op == rv_pkg::OP_EBREAK)
    };

endmodule

// ==== rtl/exu_alu.sv ====
`timescale 1ns/10ps

module exu_alu (
    input  rv_pkg::dec_t  dec,
    input  rv_pkg::xlen_t pc,
    input  rv_pkg::xlen_t rs1_data,
    input  rv_pkg::xlen_t rs2_data,
    output rv_pkg::xlen_t result
);

    logic eq;
    logic lt;
    logic ltu;
    logic cond;

    assign eq  = (rs1_data == rs2_data);
    assign lt  = ($signed(rs1_data) < $signed(rs2_data));
    assign ltu = (rs1_data < rs2_data);

    // Branch condition, already inverted for bne, bge and bgeu
    always_comb begin
        case (dec.op)
            rv_pkg::OP_BEQ:  cond = eq;
            rv_pkg::OP_BNE:  cond = !eq;
            rv_pkg::OP_BLT:  cond = lt;
            rv_pkg::OP_BGE:  cond = !lt;
            rv_pkg::OP_BLTU: cond = ltu;
            rv_pkg::OP_BGEU: cond = !ltu;
            default:         cond = 1'b0;
        endcase
    end

    always_comb begin
        case (dec.op)
            rv_pkg::OP_LUI:   result = dec.imm;
            rv_pkg::OP_AUIPC: result = pc + dec.imm;
            rv_pkg::OP_JAL,
            rv_pkg::OP_JALR:  result = pc + 32'd4;
            rv_pkg::OP_BEQ, rv_pkg::OP_BNE, rv_pkg::OP_BLT,
            rv_pkg::OP_BGE, rv_pkg::OP_BLTU, rv_pkg::OP_BGEU:
                result = rv_pkg::xlen_t'(cond);
            rv_pkg::OP_ADDI:  result = rs1_data + dec.imm;
            rv_pkg::OP_SLTIU: result = rv_pkg::xlen_t'(rs1_data < dec.imm);
            rv_pkg::OP_XORI:  result = rs1_data ^ dec.imm;
            rv_pkg::OP_ANDI:  result = rs1_data & dec.imm;
            rv_pkg::OP_SLLI:  result = rs1_data << dec.imm[4:0];
            rv_pkg::OP_SRLI:  result = rs1_data >> dec.imm[4:0];
            rv_pkg::OP_SRAI:  result = rv_pkg::xlen_t'($signed(rs1_data) >>> dec.imm[4:0]);
            rv_pkg::OP_ADD:   result = rs1_data + rs2_data;
            rv_pkg::OP_SUB:   result = rs1_data - rs2_data;
            rv_pkg::OP_SLL:   result = rs1_data << rs2_data[4:0];
            rv_pkg::OP_SLTU:  result = rv_pkg::xlen_t'(ltu);
            rv_pkg::OP_XOR:   result = rs1_data ^ rs2_data;
            rv_pkg::OP_OR:    result = rs1_data | rs2_data;
            rv_pkg::OP_AND:   result = rs1_data & rs2_data;
            default:          result = '0;
        endcase
    end

endmodule

// ==== rtl/exu_pc.sv ====
`timescale 1ns/10ps

module exu_pc (
    input  rv_pkg::dec_t  dec,
    input  rv_pkg::xlen_t pc,
    input  rv_pkg::xlen_t rs1_data,
    input  rv_pkg::xlen_t result,
    output rv_pkg::xlen_t next_pc,
    output logic          pc_w_en
);

    rv_pkg::xlen_t add_a;
    rv_pkg::xlen_t add_b;
    rv_pkg::xlen_t sum;
    logic          is_jalr;

    assign is_jalr = (dec.op == rv_pkg::OP_JALR);

    always_comb begin
        add_a = is_jalr ? rs1_data : pc;
        case (dec.op)
            rv_pkg::OP_JAL, rv_pkg::OP_JALR: add_b = dec.imm;
            rv_pkg::OP_BEQ, rv_pkg::OP_BNE, rv_pkg::OP_BLT,
            rv_pkg::OP_BGE, rv_pkg::OP_BLTU, rv_pkg::OP_BGEU:
                add_b = result[0] ? dec.imm : 32'd4;
            default: add_b = 32'd4;
        endcase
    end

    assign sum     = add_a + add_b;
    assign next_pc = {sum[31:1], sum[0] & !is_jalr};

    always_comb begin
        case (dec.itype)
            rv_pkg::TYPE_R, rv_pkg::TYPE_I, rv_pkg::TYPE_S,
            rv_pkg::TYPE_B, rv_pkg::TYPE_U, rv_pkg::TYPE_J: pc_w_en = 1'b1;
            default: pc_w_en = 1'b0;
        endcase
        a_next_pc_aligned: assert final (pc_w_en !== 1'b1 || next_pc[1:0] == 2'b00);
    end

endmodule

// ==== rtl/wbu_regfile.sv ====
`timescale 1ns/10ps

module wbu_regfile (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            retire,
    input  rv_pkg::dec_t    dec,
    input  rv_pkg::xlen_t   pc,
    input  rv_pkg::xlen_t   wr_data,
    output rv_pkg::xlen_t   rs1_data,
    output rv_pkg::xlen_t   rs2_data,
    output rv_pkg::commit_t commit
);

    rv_pkg::xlen_t     regs [31:1];
    logic              commit_valid;
    rv_pkg::xlen_t     commit_pc;
    rv_pkg::reg_addr_t commit_rd;
    logic              commit_rd_w_en;
    rv_pkg::xlen_t     commit_rd_data;

    assign rs1_data = (dec.rs1 == 5'd0) ? '0 : regs[dec.rs1];
    assign rs2_data = (dec.rs2 == 5'd0) ? '0 : regs[dec.rs2];

    // rd_w_en is never set for x0
    always_ff @(posedge clk) begin
        if (retire && dec.rd_w_en) regs[dec.rd] <= wr_data;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) commit_valid <= 1'b0;
        else commit_valid <= retire;
    end

    always_ff @(posedge clk) begin
        if (retire) begin
            commit_pc      <= pc;
            commit_rd      <= dec.rd;
            commit_rd_w_en <= dec.rd_w_en;
            commit_rd_data <= wr_data;
        end
    end

    assign commit = '{
        valid:   commit_valid,
        pc:      commit_pc,
        rd:      commit_rd,
        rd_w_en: commit_rd_w_en,
        rd_data: commit_rd_data
    };

    a_no_x0_write: assert property (@(posedge clk) disable iff (!rst_n)
        (commit.valid && commit.rd_w_en) |-> (commit.rd != 5'd0));

endmodule

// ==== rtl/rv_core_top.sv ====
`timescale 1ns/10ps

module rv_core_top #(
    parameter rv_pkg::xlen_t RESET_PC = '0
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            wb_ack,
    input  rv_pkg::xlen_t   wb_dat_i,
    output logic            wb_cyc,
    output logic            wb_stb,
    output logic            wb_we,
    output rv_pkg::xlen_t   wb_adr,
    output rv_pkg::commit_t commit,
    output logic            halted,
    output logic            trapped
);

    rv_pkg::xlen_t inst;
    rv_pkg::xlen_t pc;
    rv_pkg::xlen_t next_pc;
    rv_pkg::xlen_t rs1_data;
    rv_pkg::xlen_t rs2_data;
    rv_pkg::xlen_t result;
    rv_pkg::dec_t  dec;
    logic          retire;
    logic          pc_w_en;

    ifu_fetch #(
        .RESET_PC(RESET_PC)
    ) u_ifu_fetch (
        .clk     (clk),
        .rst_n   (rst_n),
        .wb_ack  (wb_ack),
        .wb_dat_i(wb_dat_i),
        .next_pc (next_pc),
        .pc_w_en (pc_w_en),
        .halt    (dec.halt),
        .wb_cyc  (wb_cyc),
        .wb_stb  (wb_stb),
        .wb_we   (wb_we),
        .wb_adr  (wb_adr),
        .inst    (inst),
        .pc      (pc),
        .retire  (retire),
        .halted  (halted),
        .trapped (trapped)
    );

    idu_decode u_idu_decode (
        .inst(inst),
        .dec (dec)
    );

    exu_alu u_exu_alu (
        .dec     (dec),
        .pc      (pc),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .result  (result)
    );

    exu_pc u_exu_pc (
        .dec     (dec),
        .pc      (pc),
        .rs1_data(rs1_data),
        .result  (result),
        .next_pc (next_pc),
        .pc_w_en (pc_w_en)
    );

    wbu_regfile u_wbu_regfile (
        .clk     (clk),
        .rst_n   (rst_n),
        .retire  (retire),
        .dec     (dec),
        .pc      (pc),
        .wr_data (result),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .commit  (commit)
    );

endmodule

// ==== test/tb_rv_core_top.sv ====
`timescale 1ns/10ps

module tb_rv_core_top;

    localparam rv_pkg::xlen_t RESET_PC = 32'h0000_0040;
    localparam int TIMEOUT = 50;

    localparam logic [6:0] OPC_LUI   = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC = 7'b0010111;
    localparam logic [6:0] OPC_IMM   = 7'b0010011;
    localparam logic [6:0] OPC_JALR  = 7'b1100111;

    // One program word and the commit it should produce
    typedef struct packed {
        rv_pkg::xlen_t     word;
        logic              commits;
        rv_pkg::reg_addr_t rd;
        logic              w_en;
        rv_pkg::xlen_t     data;
    } row_t;

    logic            clk;
    logic            rst_n;
    logic            wb_ack;
    rv_pkg::xlen_t   wb_dat_i;
    logic            wb_cyc;
    logic            wb_stb;
    logic            wb_we;
    rv_pkg::xlen_t   wb_adr;
    rv_pkg::commit_t commit;
    logic            halted;
    logic            trapped;

    rv_pkg::xlen_t rom [0:63];
    row_t          rows [$];
    logic [31:0]   seed;
    int            waits;
    logic          busy;

    rv_core_top #(
        .RESET_PC(RESET_PC)
    ) dut0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .wb_ack  (wb_ack),
        .wb_dat_i(wb_dat_i),
        .wb_cyc  (wb_cyc),
        .wb_stb  (wb_stb),
        .wb_we   (wb_we),
        .wb_adr  (wb_adr),
        .commit  (commit),
        .halted  (halted),
        .trapped (trapped)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic rv_pkg::xlen_t r_word(input logic [6:0] f7, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3,
                                             input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic rv_pkg::xlen_t i_word(input logic [11:0] imm, input logic [4:0] rs1,
                                             input logic [2:0] f3, input logic [4:0] rd,
                                             input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic rv_pkg::xlen_t b_word(input logic [12:0] imm, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic rv_pkg::xlen_t u_word(input logic [19:0] imm, input logic [4:0] rd,
                                             input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic rv_pkg::xlen_t j_word(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    task automatic put_word(input rv_pkg::xlen_t word, input logic commits,
                            input logic [4:0] rd, input logic w_en, input rv_pkg::xlen_t data);
        rows.push_back('{word: word, commits: commits, rd: rd, w_en: w_en, data: data});
    endtask

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input rv_pkg::xlen_t got,
                               input rv_pkg::xlen_t exp);
        if (got !== exp) begin
            stop_run($sformatf("** Error: %s got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    // Wishbone slave with 0 to 3 wait states per transfer
    always @(posedge clk) begin
        #1;
        if (wb_cyc !== 1'b1 || wb_stb !== 1'b1) begin
            busy     = 1'b0;
            wb_ack   = 1'b0;
            wb_dat_i = '0;
        end else begin
            if (!busy) begin
                seed  = lcg_next(seed);
                waits = int'(seed[17:16]);
                busy  = 1'b1;
            end
            if (waits == 0) begin
                wb_ack   = 1'b1;
                wb_dat_i = rom[wb_adr[7:2]];
                busy     = 1'b0;
            end else begin
                wb_ack   = 1'b0;
                wb_dat_i = '0;
                waits    = waits - 1;
            end
        end
    end

    task automatic apply_reset();
        @(posedge clk);
        #1 rst_n = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        check_value("wb_cyc", rv_pkg::xlen_t'(wb_cyc), '0);
        check_value("commit.valid", rv_pkg::xlen_t'(commit.valid), '0);
        check_value("halted", rv_pkg::xlen_t'(halted), '0);
        check_value("trapped", rv_pkg::xlen_t'(trapped), '0);
        rst_n = 1'b1;
    endtask

    task automatic wait_commit(input int k);
        int cycles;
        cycles = 0;
        @(negedge clk);
        check_value("wb_we", rv_pkg::xlen_t'(wb_we), '0);
        while (commit.valid !== 1'b1) begin
            if (cycles == TIMEOUT) stop_run($sformatf("Commit %0d never arrived", k));
            cycles++;
            @(negedge clk);
            check_value("wb_we", rv_pkg::xlen_t'(wb_we), '0);
        end
    endtask

    task automatic check_commit(input int k);
        row_t r;
        r = rows[k];
        wait_commit(k);
        check_value($sformatf("commit[%0d].pc", k), commit.pc,
                    RESET_PC + rv_pkg::xlen_t'(4 * k));
        check_value($sformatf("commit[%0d].rd_w_en", k), rv_pkg::xlen_t'(commit.rd_w_en),
                    rv_pkg::xlen_t'(r.w_en));
        if (r.w_en) begin
            check_value($sformatf("commit[%0d].rd", k), rv_pkg::xlen_t'(commit.rd),
                        rv_pkg::xlen_t'(r.rd));
            check_value($sformatf("commit[%0d].rd_data", k), commit.rd_data, r.data);
        end
    endtask

    // Waits for halted, or trapped when want_trap is set, with no commit on the way
    task automatic wait_state(input logic want_trap);
        int cycles;
        cycles = 0;
        @(negedge clk);
        check_value("commit.valid", rv_pkg::xlen_t'(commit.valid), '0);
        while ((want_trap ? trapped : halted) !== 1'b1) begin
            if (cycles == TIMEOUT) begin
                stop_run(want_trap ? "Core never trapped on the illegal word"
                                   : "Core never halted after ebreak");
            end
            cycles++;
            @(negedge clk);
            check_value("commit.valid", rv_pkg::xlen_t'(commit.valid), '0);
        end
    endtask

    task automatic expect_idle(input logic want_trap);
        repeat (20) begin
            @(negedge clk);
            check_value("commit.valid", rv_pkg::xlen_t'(commit.valid), '0);
            check_value("wb_cyc", rv_pkg::xlen_t'(wb_cyc), '0);
            check_value("wb_stb", rv_pkg::xlen_t'(wb_stb), '0);
            check_value("halted", rv_pkg::xlen_t'(halted), rv_pkg::xlen_t'(!want_trap));
            check_value("trapped", rv_pkg::xlen_t'(trapped), rv_pkg::xlen_t'(want_trap));
            // PC holds on the illegal word
            if (want_trap) begin
                check_value("wb_adr", wb_adr, RESET_PC + 32'd4);
            end
        end
    endtask

    initial begin
        rv_pkg::xlen_t skip;
        clk      = 1'b0;
        rst_n    = 1'b0;
        wb_ack   = 1'b0;
        wb_dat_i = '0;
        seed     = 32'h538c;
        waits    = 0;
        busy     = 1'b0;
        // Words a taken branch or jump steps over
        skip = i_word(12'd1, 5'd0, 3'b000, 5'd31, OPC_IMM);

        put_word(u_word(20'h12345, 5'd1, OPC_LUI), 1, 5'd1, 1, 32'h1234_5000);
        put_word(u_word(20'h00001, 5'd2, OPC_AUIPC), 1, 5'd2, 1, 32'h0000_1044);
        put_word(i_word(12'hfff, 5'd0, 3'b000, 5'd3, OPC_IMM), 1, 5'd3, 1, 32'hffff_ffff);
        put_word(i_word(12'd5, 5'd0, 3'b000, 5'd4, OPC_IMM), 1, 5'd4, 1, 32'h0000_0005);
        put_word(r_word(7'h20, 5'd4, 5'd0, 3'b000, 5'd5), 1, 5'd5, 1, 32'hffff_fffb);
        put_word(i_word({7'h20, 5'd1}, 5'd5, 3'b101, 5'd6, OPC_IMM), 1, 5'd6, 1, 32'hffff_fffd);
        put_word(i_word(12'd4, 5'd5, 3'b101, 5'd7, OPC_IMM), 1, 5'd7, 1, 32'h0fff_ffff);
        put_word(i_word(12'd31, 5'd4, 3'b001, 5'd8, OPC_IMM), 1, 5'd8, 1, 32'h8000_0000);
        put_word(i_word(12'hfff, 5'd4, 3'b011, 5'd9, OPC_IMM), 1, 5'd9, 1, 32'h0000_0001);
        put_word(r_word(7'h00, 5'd4, 5'd3, 3'b011, 5'd10), 1, 5'd10, 1, 32'h0000_0000);
        put_word(i_word(12'd35, 5'd0, 3'b000, 5'd11, OPC_IMM), 1, 5'd11, 1, 32'h0000_0023);
        put_word(r_word(7'h00, 5'd11, 5'd4, 3'b001, 5'd12), 1, 5'd12, 1, 32'h0000_0028);
        put_word(i_word(12'h0ff, 5'd1, 3'b100, 5'd13, OPC_IMM), 1, 5'd13, 1, 32'h1234_50ff);
        put_word(i_word(12'h7f0, 5'd3, 3'b111, 5'd14, OPC_IMM), 1, 5'd14, 1, 32'h0000_07f0);
        put_word(r_word(7'h00, 5'd3, 5'd1, 3'b100, 5'd15), 1, 5'd15, 1, 32'hedcb_afff);
        put_word(r_word(7'h00, 5'd8, 5'd4, 3'b110, 5'd16), 1, 5'd16, 1, 32'h8000_0005);
        put_word(r_word(7'h00, 5'd7, 5'd13, 3'b111, 5'd17), 1, 5'd17, 1, 32'h0234_50ff);
        put_word(r_word(7'h00, 5'd4, 5'd4, 3'b000, 5'd0), 1, 5'd0, 0, '0);
        put_word(r_word(7'h00, 5'd4, 5'd4, 3'b000, 5'd18), 1, 5'd18, 1, 32'h0000_000a);
        // Each branch taken, then not taken; x3 is -1 and x4 is 5
        put_word(b_word(13'd8, 5'd4, 5'd4, 3'b000), 1, 5'd0, 0, '0);
        put_word(skip, 0, 5'd0, 0, '0);
        put_word(b_word(13'd8, 5'd3, 5'd4, 3'b000), 1, 5'd0, 0, '0);
        put_word(b_word(13'd8, 5'd3, 5'd4, 3'b001), 1, 5'd0, 0, '0);
        put_word(skip, 0, 5'd0, 0, '0);
        put_word(b_word(13'd8, 5'd4, 5'd4, 3'b001), 1, 5'd0, 0, '0);
        put_word(b_word(13'd8, 5'd4, 5'd3, 3'b100), 1, 5'd0, 0, '0);
        put_word(skip, 0, 5'd0, 0, '0);
        put_word(b_word(13'd8, 5'd3, 5'd4, 3'b100), 1, 5'd0, 0, '0);
        put_word(b_word(13'd8, 5'd3, 5'd4, 3'b101), 1, 5'd0, 0, '0);
        put_word(skip, 0, 5'd0, 0, '0);
        put_word(b_word(13'd8, 5'd4, 5'd3, 3'b101), 1, 5'd0, 0, '0);
        put_word(b_word(13'd8, 5'd3, 5'd4, 3'b110), 1, 5'd0, 0, '0);
        put_word(skip, 0, 5'd0, 0, '0);
        put_word(b_word(13'd8, 5'd4, 5'd3, 3'b110), 1, 5'd0, 0, '0);
        put_word(b_word(13'd8, 5'd4, 5'd3, 3'b111), 1, 5'd0, 0, '0);
        put_word(skip, 0, 5'd0, 0, '0);
        put_word(b_word(13'd8, 5'd3, 5'd4, 3'b111), 1, 5'd0, 0, '0);
        put_word(j_word(21'd8, 5'd19), 1, 5'd19, 1, 32'h0000_00d8);
        put_word(skip, 0, 5'd0, 0, '0);
        put_word(i_word(12'h0e5, 5'd0, 3'b000, 5'd20, OPC_IMM), 1, 5'd20, 1, 32'h0000_00e5);
        // Target 0xe9 lands on 0xe8
        put_word(i_word(12'd4, 5'd20, 3'b000, 5'd21, OPC_JALR), 1, 5'd21, 1, 32'h0000_00e4);
        put_word(skip, 0, 5'd0, 0, '0);
        put_word(32'h0010_0073, 1, 5'd0, 0, '0);

        for (int i = 0; i < 64; i++) begin
            rom[i] = rv_pkg::xlen_t'(i) << 7;
        end
        for (int k = 0; k < rows.size(); k++) begin
            rom[RESET_PC[7:2] + k] = rows[k].word;
        end

        apply_reset();
        for (int k = 0; k < rows.size(); k++) begin
            if (rows[k].commits) check_commit(k);
        end
        wait_state(1'b0);
        expect_idle(1'b0);

        // Second run traps on an illegal word right after the lui
        rom[RESET_PC[7:2] + 1] = 32'hffff_ffff;
        apply_reset();
        check_commit(0);
        wait_state(1'b1);
        expect_idle(1'b1);

        $display("All tests passed");
        $finish;
    end

endmodule

// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - rtl/rv_pkg.sv
  - rtl/ifu_fetch.sv
  - rtl/idu_decode.sv
  - rtl/exu_alu.sv
  - rtl/exu_pc.sv
  - rtl/wbu_regfile.sv
  - rtl/rv_core_top.sv
  - target: test
    files:
      - test/tb_rv_core_top.sv

// ==== rv_core.f ====
rtl/rv_pkg.sv
rtl/ifu_fetch.sv
rtl/idu_decode.sv
rtl/exu_alu.sv
rtl/exu_pc.sv
rtl/wbu_regfile.sv
rtl/rv_core_top.sv
test/tb_rv_core_top.sv
